// File: Bender.yml
package:
  name: periph_padframe

export_include_dirs:
  - logic

sources:
  - logic/pad_mux_pkg.sv
  - logic/reg_bus_pkg.sv
  - logic/pad_cfg_regs.sv
  - logic/pad_out_mux.sv
  - logic/pad_in_demux.sv
  - logic/periph_padframe.sv
  - target: test
    files:
      - dv/periph_padframe_chk.sv
      - dv/periph_padframe_tb.sv

// File: dv/periph_padframe_chk.sv
// Pad frame assertions

`timescale 1ns/100ps

`include "padframe_params.svh"

module periph_padframe_chk (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic                      reg_ready_i,
  input logic                      reg_error_i,
  input pad_mux_pkg::pad_sel_vec_t pad_sel_i,
  input pad_mux_pkg::pad_vec_t     pad_oe_i
);

  import pad_mux_pkg::*;

  pad_vec_t released;
  int       fail_cnt = 0;

  // Pads whose select never drives
  always_comb begin
    for (int i = 0; i < `PAD_NUM; i++) begin
      released[i] = pad_func_e'(pad_sel_i[i*FUNC_W +: FUNC_W])
                    inside {FUNC_UART_RX, FUNC_SPI_SDI, FUNC_NONE};
    end
  end

  ready_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_ready_i |=> !reg_ready_i)
    else begin
      $error("Register ready high for two cycles in a row");
      fail_cnt++;
    end

  error_with_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_error_i |-> reg_ready_i)
    else begin
      $error("Register error raised without ready");
      fail_cnt++;
    end

  for (genvar i = 0; i < `PAD_NUM; i++) begin : g_release
    oe_released: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      released[i] |=> !pad_oe_i[i])
      else begin
        $error("Pad %0d enabled after an input-only or disabled select", i);
        fail_cnt++;
      end
  end

endmodule

bind periph_padframe periph_padframe_chk chk_inst (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .reg_ready_i ( reg_ready_o ),
  .reg_error_i ( reg_error_o ),
  .pad_sel_i   ( pad_sel     ),
  .pad_oe_i    ( pad_oe_o    )
);

// File: dv/periph_padframe_tb.sv
// Pad frame testbench

`timescale 1ns/100ps

`include "padframe_params.svh"

module periph_padframe_tb;

  import pad_mux_pkg::*;
  import reg_bus_pkg::*;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 16;
  localparam int READY_TIMEOUT = 20;

  logic      clk;
  logic      rst_n;
  logic      reg_valid;
  logic      reg_write;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata;
  logic      reg_ready;
  logic      reg_error;
  reg_data_t reg_rdata;
  pad_vec_t  gpio_out;
  pad_vec_t  gpio_dir;
  logic      uart_tx;
  logic      spi_sck;
  logic      spi_csn;
  logic      spi_sdo;
  pad_vec_t  pad_out;
  pad_vec_t  pad_oe;
  pad_vec_t  pad_in;
  pad_vec_t  gpio_in;
  logic      uart_rx;
  logic      spi_sdi;

  integer    seed;
  int        err_cnt;
  int        test_cnt;
  int        test_err_base;
  pad_func_e sel_model [`PAD_NUM];
  pad_vec_t  exp_out;
  pad_vec_t  exp_oe;

  periph_padframe periph_padframe_inst (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .reg_valid_i ( reg_valid ),
    .reg_write_i ( reg_write ),
    .reg_addr_i  ( reg_addr  ),
    .reg_wdata_i ( reg_wdata ),
    .reg_ready_o ( reg_ready ),
    .reg_error_o ( reg_error ),
    .reg_rdata_o ( reg_rdata ),
    .gpio_out_i  ( gpio_out  ),
    .gpio_dir_i  ( gpio_dir  ),
    .uart_tx_i   ( uart_tx   ),
    .spi_sck_i   ( spi_sck   ),
    .spi_csn_i   ( spi_csn   ),
    .spi_sdo_i   ( spi_sdo   ),
    .pad_out_o   ( pad_out   ),
    .pad_oe_o    ( pad_oe    ),
    .pad_in_i    ( pad_in    ),
    .gpio_in_o   ( gpio_in   ),
    .uart_rx_o   ( uart_rx   ),
    .spi_sdi_o   ( spi_sdi   )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_reg(input string what, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_pads(input string what, input pad_vec_t got, input pad_vec_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("%-18s %s, %0d errors", name, (err_cnt == test_err_base) ? "ok" : "failed",
             err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  // Called on a falling edge, returns on the falling edge that shows ready
  task automatic reg_access(input logic write, input reg_addr_t addr, input reg_data_t wdata,
                            output reg_data_t rdata, output logic err);
    int cycles;
    cycles    = 0;
    reg_valid = 1'b1;
    reg_write = write;
    reg_addr  = addr;
    reg_wdata = wdata;
    @(negedge clk);
    while (!reg_ready && cycles < READY_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!reg_ready) begin
      $display("Register access to address %h got no ready within %0d cycles",
               addr, READY_TIMEOUT);
      err_cnt++;
    end
    rdata     = reg_rdata;
    err       = reg_error;
    reg_valid = 1'b0;
  endtask

  task automatic write_sel(input pad_idx_t idx, input reg_data_t wdata);
    reg_data_t rdata;
    logic      err;
    reg_access(1'b1, reg_addr_t'(4 * idx), wdata, rdata, err);
    check_bit("write error flag", err, 1'b0);
    sel_model[idx] = pad_func_e'(wdata[2:0]);
  endtask

  task automatic read_sel(input pad_idx_t idx);
    reg_data_t rdata;
    logic      err;
    reg_access(1'b0, reg_addr_t'(4 * idx), '0, rdata, err);
    check_bit("read error flag", err, 1'b0);
    check_reg("select readback", rdata, reg_data_t'(sel_model[idx]));
  endtask

  task automatic drive_periph();
    gpio_out = pad_vec_t'($random(seed));
    gpio_dir = pad_vec_t'($random(seed));
    {uart_tx, spi_sck, spi_csn, spi_sdo} = 4'($random(seed));
  endtask

  // Expected pads one cycle after the current inputs
  task automatic predict_pads();
    exp_out = '0;
    exp_oe  = '0;
    for (int i = 0; i < `PAD_NUM; i++) begin
      case (sel_model[i])
        FUNC_GPIO:    {exp_oe[i], exp_out[i]} = {gpio_dir[i], gpio_out[i]};
        FUNC_UART_TX: {exp_oe[i], exp_out[i]} = {1'b1, uart_tx};
        FUNC_SPI_SCK: {exp_oe[i], exp_out[i]} = {1'b1, spi_sck};
        FUNC_SPI_CSN: {exp_oe[i], exp_out[i]} = {1'b1, spi_csn};
        FUNC_SPI_SDO: {exp_oe[i], exp_out[i]} = {1'b1, spi_sdo};
        default:      {exp_oe[i], exp_out[i]} = 2'b00;
      endcase
    end
  endtask

  function automatic logic model_pick(input pad_vec_t pads, input pad_func_e f, input logic idle);
    for (int i = 0; i < `PAD_NUM; i++) begin
      if (sel_model[i] == f) begin
        return pads[i];
      end
    end
    return idle;
  endfunction

  initial begin
    reg_data_t rdata;
    logic      err;
    reg_addr_t addr;
    pad_func_e f;
    pad_idx_t  old_pad;
    pad_idx_t  new_pad;
    pad_idx_t  pend_idx;
    pad_func_e pend_func;
    pad_vec_t  v;
    pad_vec_t  hist [$];
    int        done_cnt;
    seed          = 45435;
    err_cnt       = 0;
    test_cnt      = 0;
    test_err_base = 0;
    clk       = 1'b0;
    rst_n     = 1'b0;
    reg_valid = 1'b0;
    reg_write = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    gpio_out  = '0;
    gpio_dir  = '0;
    uart_tx   = 1'b0;
    spi_sck   = 1'b0;
    spi_csn   = 1'b0;
    spi_sdo   = 1'b0;
    pad_in    = '0;
    for (int i = 0; i < `PAD_NUM; i++) begin
      sel_model[i] = FUNC_GPIO;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    check_pads("pad_oe_o after reset", pad_oe, '0);
    check_bit("uart_rx_o after reset", uart_rx, 1'b1);
    for (int i = 0; i < `PAD_NUM; i++) begin
      read_sel(pad_idx_t'(i));
    end
    end_test("reset state");

    for (int n = 0; n < 24; n++) begin
      write_sel(pad_idx_t'($random(seed)), $random(seed));
      read_sel(pad_idx_t'($random(seed)));
    end
    for (int n = 0; n < 8; n++) begin
      addr = reg_addr_t'($random(seed));
      if (addr[1:0] == 2'b00 && addr <= 4 * (`PAD_NUM - 1)) begin
        addr[5] = 1'b1;
      end
      reg_access(n[0], addr, $random(seed), rdata, err);
      check_bit("error flag on bad address", err, 1'b1);
      check_reg("read data on bad address", rdata, '0);
    end
    for (int i = 0; i < `PAD_NUM; i++) begin
      read_sel(pad_idx_t'(i));
    end
    end_test("register access");

    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < `PAD_NUM; i++) begin
        write_sel(pad_idx_t'(i), $random(seed));
      end
      drive_periph();
      predict_pads();
      for (int n = 0; n < 10; n++) begin
        @(negedge clk);
        check_pads("pad_out_o", pad_out, exp_out);
        check_pads("pad_oe_o", pad_oe, exp_oe);
        drive_periph();
        predict_pads();
      end
    end
    end_test("output routing");

    // Round 0 has no input functions, round 1 shares each one across pads
    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < `PAD_NUM; i++) begin
        case (r)
          0:       f = FUNC_GPIO;
          1:       f = i[0] ? FUNC_UART_RX : FUNC_SPI_SDI;
          default: f = pad_func_e'($random(seed));
        endcase
        write_sel(pad_idx_t'(i), reg_data_t'(f));
      end
      hist.delete();
      for (int n = 0; n < 20; n++) begin
        if (hist.size() == 2) begin
          v = hist.pop_front();
          check_pads("gpio_in_o", gpio_in, v);
          check_bit("uart_rx_o", uart_rx, model_pick(v, FUNC_UART_RX, 1'b1));
          check_bit("spi_sdi_o", spi_sdi, model_pick(v, FUNC_SPI_SDI, 1'b0));
        end
        pad_in = pad_vec_t'($random(seed));
        hist.push_back(pad_in);
        @(negedge clk);
      end
    end
    end_test("input routing");

    old_pad = pad_idx_t'($random(seed));
    new_pad = old_pad + pad_idx_t'(1 + {$random(seed)} % 7);
    f       = pad_func_e'($random(seed));
    if (f == FUNC_UART_TX) begin
      f = FUNC_NONE;
    end
    write_sel(old_pad, reg_data_t'(FUNC_UART_TX));
    done_cnt = 0;
    drive_periph();
    predict_pads();
    for (int n = 0; n < 12; n++) begin
      @(negedge clk);
      check_pads("pad_out_o", pad_out, exp_out);
      check_pads("pad_oe_o", pad_oe, exp_oe);
      if (reg_valid && reg_ready) begin
        check_bit("write error flag", reg_error, 1'b0);
        sel_model[pend_idx] = pend_func;
        reg_valid = 1'b0;
        done_cnt++;
      end
      if (n == 2 || n == 7) begin
        pend_idx  = (n == 2) ? new_pad : old_pad;
        pend_func = (n == 2) ? FUNC_UART_TX : f;
        reg_valid = 1'b1;
        reg_write = 1'b1;
        reg_addr  = reg_addr_t'(4 * pend_idx);
        reg_wdata = reg_data_t'(pend_func);
      end
      drive_periph();
      uart_tx = n[0];
      predict_pads();
    end
    if (done_cnt != 2) begin
      $display("Reconfiguration writes did not complete, %0d of 2 saw ready", done_cnt);
      err_cnt++;
    end
    end_test("reconfiguration");

    err_cnt += periph_padframe_inst.chk_inst.fail_cnt;
    $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: logic/pad_cfg_regs.sv
// Pad select register bank

`timescale 1ns/100ps

`include "padframe_params.svh"

module pad_cfg_regs (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      reg_valid_i,
  input  logic                      reg_write_i,
  input  reg_bus_pkg::reg_addr_t    reg_addr_i,
  input  reg_bus_pkg::reg_data_t    reg_wdata_i,
  output logic                      reg_ready_o,
  output logic                      reg_error_o,
  output reg_bus_pkg::reg_data_t    reg_rdata_o,
  output pad_mux_pkg::pad_sel_vec_t pad_sel_o
);

  import reg_bus_pkg::*;
  import pad_mux_pkg::*;

  reg_state_e   state_q;
  pad_sel_vec_t sel_q;
  reg_data_t    rdata_q;
  logic         err_q;
  logic         addr_ok;
  pad_idx_t     idx;

  // Word aligned and inside the select table
  assign addr_ok = (reg_addr_i[1:0] == 2'b00) &&
                   (reg_addr_i <= reg_addr_t'(4 * (`PAD_NUM - 1)));
  assign idx = pad_idx_t'(reg_addr_i >> 2);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= REG_IDLE;
      sel_q   <= {`PAD_NUM{FUNC_GPIO}};
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        REG_IDLE: begin
          if (reg_valid_i) begin
            state_q <= REG_RESP;
            err_q   <= !addr_ok;
            if (addr_ok && reg_write_i) begin
              sel_q[idx*FUNC_W +: FUNC_W] <= reg_wdata_i[FUNC_W-1:0];
            end
          end
        end
        REG_RESP: begin
          // Single response cycle, then free for the next request
          state_q <= REG_IDLE;
          err_q   <= 1'b0;
        end
        default: begin
          state_q <= REG_IDLE;
        end
      endcase
    end
  end

  // Read data, zero for writes and bad addresses
  always_ff @(posedge clk_i) begin
    if (state_q == REG_IDLE && reg_valid_i) begin
      rdata_q <= '0;
      if (addr_ok && !reg_write_i) begin
        rdata_q[FUNC_W-1:0] <= sel_q[idx*FUNC_W +: FUNC_W];
      end
    end
  end

  assign reg_ready_o = (state_q == REG_RESP);
  assign reg_error_o = err_q;
  assign reg_rdata_o = rdata_q;
  assign pad_sel_o   = sel_q;

endmodule

// File: logic/pad_in_demux.sv
// Pad to SoC input routing

`timescale 1ns/100ps

`include "padframe_params.svh"

module pad_in_demux (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  pad_mux_pkg::pad_sel_vec_t pad_sel_i,
  input  pad_mux_pkg::pad_vec_t     pad_in_i,
  output pad_mux_pkg::pad_vec_t     gpio_in_o,
  output logic                      uart_rx_o,
  output logic                      spi_sdi_o
);

  import pad_mux_pkg::*;

  pad_vec_t  sync_q [`SYNC_STAGES];
  pad_vec_t  pad_sync;
  pad_func_e func;

  // Synchronizer chain on all pad inputs
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < `SYNC_STAGES; s++) begin
        sync_q[s] <= '0;
      end
    end else begin
      sync_q[0] <= pad_in_i;
      for (int s = 1; s < `SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  assign pad_sync  = sync_q[`SYNC_STAGES-1];
  assign gpio_in_o = pad_sync;

  // Walk from the top pad down so the lowest index wins
  always_comb begin
    uart_rx_o = 1'b1;
    spi_sdi_o = 1'b0;
    for (int i = `PAD_NUM - 1; i >= 0; i--) begin
      func = pad_func_e'(pad_sel_i[i*FUNC_W +: FUNC_W]);
      if (func == FUNC_UART_RX) begin
        uart_rx_o = pad_sync[i];
      end
      if (func == FUNC_SPI_SDI) begin
        spi_sdi_o = pad_sync[i];
      end
    end
  end

endmodule

// File: logic/pad_mux_pkg.sv
// Pad and pad function types

`include "padframe_params.svh"

package pad_mux_pkg;

  // Bits of one function select
  localparam int FUNC_W = 3;

  typedef logic [`PAD_NUM-1:0] pad_vec_t;
  typedef logic [2:0] pad_idx_t;

  typedef enum logic [FUNC_W-1:0] {
    FUNC_GPIO    = 3'd0,
    FUNC_UART_TX = 3'd1,
    FUNC_UART_RX = 3'd2,
    FUNC_SPI_SCK = 3'd3,
    FUNC_SPI_CSN = 3'd4,
    FUNC_SPI_SDO = 3'd5,
    FUNC_SPI_SDI = 3'd6,
    FUNC_NONE    = 3'd7
  } pad_func_e;

  // Pad i select in bits [i*FUNC_W +: FUNC_W]
  typedef logic [`PAD_NUM*FUNC_W-1:0] pad_sel_vec_t;

endpackage

// File: logic/pad_out_mux.sv
// SoC to pad output routing

`timescale 1ns/100ps

`include "padframe_params.svh"

module pad_out_mux (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  pad_mux_pkg::pad_sel_vec_t pad_sel_i,
  input  pad_mux_pkg::pad_vec_t     gpio_out_i,
  input  pad_mux_pkg::pad_vec_t     gpio_dir_i,
  input  logic                      uart_tx_i,
  input  logic                      spi_sck_i,
  input  logic                      spi_csn_i,
  input  logic                      spi_sdo_i,
  output pad_mux_pkg::pad_vec_t     pad_out_o,
  output pad_mux_pkg::pad_vec_t     pad_oe_o
);

  import pad_mux_pkg::*;

  pad_vec_t  out_d;
  pad_vec_t  oe_d;
  pad_func_e func;

  always_comb begin
    out_d = '0;
    oe_d  = '0;
    for (int i = 0; i < `PAD_NUM; i++) begin
      func = pad_func_e'(pad_sel_i[i*FUNC_W +: FUNC_W]);
      case (func)
        FUNC_GPIO: begin
          out_d[i] = gpio_out_i[i];
          oe_d[i]  = gpio_dir_i[i];
        end
        FUNC_UART_TX: begin
          out_d[i] = uart_tx_i;
          oe_d[i]  = 1'b1;
        end
        FUNC_SPI_SCK: begin
          out_d[i] = spi_sck_i;
          oe_d[i]  = 1'b1;
        end
        FUNC_SPI_CSN: begin
          out_d[i] = spi_csn_i;
          oe_d[i]  = 1'b1;
        end
        FUNC_SPI_SDO: begin
          out_d[i] = spi_sdo_i;
          oe_d[i]  = 1'b1;
        end
        // Input-only and disabled pads stay released
        default: begin
          out_d[i] = 1'b0;
          oe_d[i]  = 1'b0;
        end
      endcase
    end
  end

  // Registered so pads never see decode glitches
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pad_out_o <= '0;
      pad_oe_o  <= '0;
    end else begin
      pad_out_o <= out_d;
      pad_oe_o  <= oe_d;
    end
  end

endmodule

// File: logic/padframe_params.svh
// Pad frame parameters

`ifndef PADFRAME_PARAMS_SVH
`define PADFRAME_PARAMS_SVH

// Number of multiplexed pads
`define PAD_NUM 8

// Configuration register bus
`define REG_AW 8
`define REG_DW 32

// Input synchronizer depth
`define SYNC_STAGES 2

`endif

// File: logic/periph_padframe.sv
// Peripheral pad multiplexer

`timescale 1ns/100ps

module periph_padframe (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Configuration register bus
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  reg_bus_pkg::reg_addr_t reg_addr_i,
  input  reg_bus_pkg::reg_data_t reg_wdata_i,
  output logic                   reg_ready_o,
  output logic                   reg_error_o,
  output reg_bus_pkg::reg_data_t reg_rdata_o,
  // Peripheral outputs
  input  pad_mux_pkg::pad_vec_t  gpio_out_i,
  input  pad_mux_pkg::pad_vec_t  gpio_dir_i,
  input  logic                   uart_tx_i,
  input  logic                   spi_sck_i,
  input  logic                   spi_csn_i,
  input  logic                   spi_sdo_i,
  // Pad side
  output pad_mux_pkg::pad_vec_t  pad_out_o,
  output pad_mux_pkg::pad_vec_t  pad_oe_o,
  input  pad_mux_pkg::pad_vec_t  pad_in_i,
  // Peripheral inputs
  output pad_mux_pkg::pad_vec_t  gpio_in_o,
  output logic                   uart_rx_o,
  output logic                   spi_sdi_o
);

  import pad_mux_pkg::*;

  pad_sel_vec_t pad_sel;

  pad_cfg_regs i_pad_cfg_regs (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .reg_valid_i ( reg_valid_i ),
    .reg_write_i ( reg_write_i ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .reg_ready_o ( reg_ready_o ),
    .reg_error_o ( reg_error_o ),
    .reg_rdata_o ( reg_rdata_o ),
    .pad_sel_o   ( pad_sel     )
  );

  pad_out_mux i_pad_out_mux (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .pad_sel_i  ( pad_sel    ),
    .gpio_out_i ( gpio_out_i ),
    .gpio_dir_i ( gpio_dir_i ),
    .uart_tx_i  ( uart_tx_i  ),
    .spi_sck_i  ( spi_sck_i  ),
    .spi_csn_i  ( spi_csn_i  ),
    .spi_sdo_i  ( spi_sdo_i  ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   )
  );

  pad_in_demux i_pad_in_demux (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .pad_sel_i ( pad_sel   ),
    .pad_in_i  ( pad_in_i  ),
    .gpio_in_o ( gpio_in_o ),
    .uart_rx_o ( uart_rx_o ),
    .spi_sdi_o ( spi_sdi_o )
  );

endmodule

// File: logic/reg_bus_pkg.sv
// Configuration register bus types

`include "padframe_params.svh"

package reg_bus_pkg;

  typedef logic [`REG_AW-1:0] reg_addr_t;
  typedef logic [`REG_DW-1:0] reg_data_t;

  // Register bank handshake FSM
  typedef enum logic {
    REG_IDLE = 1'b0,
    REG_RESP = 1'b1
  } reg_state_e;

endpackage

// File: project.f
+incdir+logic
logic/pad_mux_pkg.sv
logic/reg_bus_pkg.sv
logic/pad_cfg_regs.sv
logic/pad_out_mux.sv
logic/pad_in_demux.sv
logic/periph_padframe.sv
dv/periph_padframe_chk.sv
dv/periph_padframe_tb.sv
